/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_fpga_fabric
FILELIST ?= fpga_fabric.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

/* fpga_fabric.f */
+incdir+src
src/fabric_pkg.sv
src/clb_link_if.sv
src/config_loader.sv
src/connection_block.sv
src/clb.sv
src/io_block.sv
src/fpga_fabric.sv
verification/fabric_checker.sv
verification/tb_fpga_fabric.sv

/* src/clb.sv */
`timescale 1ns/100ps

module clb (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic [$bits(fabric_pkg::lut_t)+1:0]  cfg,
   clb_link_if.logic_blk                        link
);

   localparam int LUT_W = $bits(fabric_pkg::lut_t);

   fabric_pkg::lut_t lut;
   logic reg_en;
   logic carry_mode;
   logic sum;
   logic maj;
   logic value;
   logic value_q;

   assign lut        = cfg[LUT_W-1:0];
   assign reg_en     = cfg[LUT_W];
   assign carry_mode = cfg[LUT_W+1];

   // full adder on ins[1:0] and the incoming carry
   assign sum = link.ins[0] ^ link.ins[1] ^ link.cin;
   assign maj = (link.ins[0] & link.ins[1]) |
                (link.ins[0] & link.cin) |
                (link.ins[1] & link.cin);

   assign value     = carry_mode ? sum : lut[link.ins];
   assign link.cout = carry_mode & maj; // chain is cut in lut mode

   always_ff @(posedge clk) begin
      if (rst) begin
         value_q <= 1'b0;
      end else begin
         value_q <= value;
      end
   end

   assign link.result = reg_en ? value_q : value;

endmodule

/* src/clb_link_if.sv */
`timescale 1ns/100ps

interface clb_link_if;

   fabric_pkg::clb_in_t ins;
   logic cin;
   logic cout; // toward the next clb down the column
   logic result;

   modport route (
      output ins,
      output cin,
      input  cout
   );

   modport logic_blk (
      input  ins,
      input  cin,
      output cout,
      output result
   );

   modport drain (
      input  result
   );

endinterface

/* src/config_loader.sv */
`timescale 1ns/100ps
`include "fabric_params.svh"

module config_loader (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   cfg_valid,
   input  logic                   cfg_bit,
   output logic                   cfg_done,
   output fabric_pkg::route_cfg_t route_cfg,
   output fabric_pkg::clb_cfg_t   clb_cfg,
   output fabric_pkg::io_cfg_t    io_cfg
);

   localparam int ROUTE_W = $bits(fabric_pkg::route_cfg_t);
   localparam int CLB_W = $bits(fabric_pkg::clb_cfg_t);
   localparam int IO_W = $bits(fabric_pkg::io_cfg_t);

   typedef logic [$clog2(`FABRIC_CFG_BITS)-1:0] cnt_t;
   localparam cnt_t LAST_BIT = cnt_t'(`FABRIC_CFG_BITS - 1);

   fabric_pkg::cfg_state_t state;
   fabric_pkg::cfg_frame_t frame;
   cnt_t bit_cnt;
   logic accept;

   assign accept = cfg_valid && (state == fabric_pkg::load);

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= fabric_pkg::load;
         frame   <= '0;
         bit_cnt <= '0;
      end else if (accept) begin
         // first bit in ends up at bit 0
         frame   <= {cfg_bit, frame[`FABRIC_CFG_BITS-1:1]};
         bit_cnt <= bit_cnt + 1'b1;
         if (bit_cnt == LAST_BIT) begin
            state <= fabric_pkg::done; // bits after this are dropped
         end
      end
   end

   assign cfg_done = (state == fabric_pkg::done);

   // fabric sees an all-zero config until the frame is complete
   assign route_cfg = cfg_done ? frame[ROUTE_W-1:0] : '0;
   assign clb_cfg   = cfg_done ? frame[ROUTE_W +: CLB_W] : '0;
   assign io_cfg    = cfg_done ? frame[ROUTE_W+CLB_W +: IO_W] : '0;

endmodule

/* src/connection_block.sv */
`timescale 1ns/100ps
`include "fabric_params.svh"

module connection_block (
   input  fabric_pkg::track_t     ext_in,
   input  fabric_pkg::route_cfg_t route_cfg,
   clb_link_if.route              links [`FABRIC_NUM_CLB]
);

   for (genvar i = 0; i < `FABRIC_NUM_CLB; i++) begin : g_clb
      fabric_pkg::clb_in_t ins_mux;

      // one track mux per clb input
      always_comb begin
         fabric_pkg::track_sel_t sel;
         for (int j = 0; j < `FABRIC_CLBIN; j++) begin
            sel = route_cfg[(i*`FABRIC_CLBIN + j)*`FABRIC_SEL_W +: `FABRIC_SEL_W];
            ins_mux[j] = ext_in[sel];
         end
      end

      assign links[i].ins = ins_mux;

      // carry runs top to bottom, chain starts at zero
      if (i == 0) begin : g_chain_head
         assign links[i].cin = 1'b0;
      end else begin : g_chain_link
         assign links[i].cin = links[i-1].cout;
      end
   end

endmodule

/* src/fabric_params.svh */
`ifndef FABRIC_PARAMS_SVH
`define FABRIC_PARAMS_SVH

// column size
`define FABRIC_NUM_CLB 4
`define FABRIC_CLBIN 4

// input side
`define FABRIC_TRACKS 8
`define FABRIC_SEL_W 3 // picks one of the tracks

// output side
`define FABRIC_NUM_OUT 4
`define FABRIC_OSEL_W 2 // picks one of the clbs

// route 48 + clb 72 + io 8
`define FABRIC_CFG_BITS 128

`endif

/* src/fabric_pkg.sv */
`include "fabric_params.svh"

package fabric_pkg;

   typedef logic [`FABRIC_TRACKS-1:0] track_t;
   typedef logic [`FABRIC_CLBIN-1:0] clb_in_t;
   typedef logic [(1 << `FABRIC_CLBIN)-1:0] lut_t; // one bit per input pattern

   typedef logic [`FABRIC_SEL_W-1:0] track_sel_t;
   typedef logic [`FABRIC_OSEL_W-1:0] out_sel_t;
   typedef logic [`FABRIC_NUM_OUT-1:0] ext_out_t;

   // configuration frame, split in the order it is loaded
   typedef logic [`FABRIC_NUM_CLB*`FABRIC_CLBIN*`FABRIC_SEL_W-1:0] route_cfg_t;
   // per clb: truth table, register enable, carry mode
   typedef logic [`FABRIC_NUM_CLB*($bits(lut_t)+2)-1:0] clb_cfg_t;
   typedef logic [`FABRIC_NUM_OUT*`FABRIC_OSEL_W-1:0] io_cfg_t;
   typedef logic [`FABRIC_CFG_BITS-1:0] cfg_frame_t;

   typedef enum logic {
      load,
      done
   } cfg_state_t;

endpackage

/* src/fpga_fabric.sv */
`timescale 1ns/100ps
`include "fabric_params.svh"

module fpga_fabric (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cfg_valid,
   input  logic                 cfg_bit,
   input  fabric_pkg::track_t   ext_in,
   output logic                 cfg_done,
   output fabric_pkg::ext_out_t ext_out
);

   localparam int CLB_CFG_W = $bits(fabric_pkg::lut_t) + 2;

   fabric_pkg::route_cfg_t route_cfg;
   fabric_pkg::clb_cfg_t clb_cfg;
   fabric_pkg::io_cfg_t io_cfg;

   clb_link_if link [`FABRIC_NUM_CLB] ();

   config_loader loader_inst (
      .clk       (clk),
      .rst       (rst),
      .cfg_valid (cfg_valid),
      .cfg_bit   (cfg_bit),
      .cfg_done  (cfg_done),
      .route_cfg (route_cfg),
      .clb_cfg   (clb_cfg),
      .io_cfg    (io_cfg)
   );

   connection_block cb_inst (
      .ext_in    (ext_in),
      .route_cfg (route_cfg),
      .links     (link)
   );

   // single column, clb 0 on top of the carry chain
   for (genvar i = 0; i < `FABRIC_NUM_CLB; i++) begin : g_clbs
      clb clb_inst (
         .clk  (clk),
         .rst  (rst),
         .cfg  (clb_cfg[i*CLB_CFG_W +: CLB_CFG_W]),
         .link (link[i])
      );
   end

   io_block iob_inst (
      .clk      (clk),
      .rst      (rst),
      .cfg_done (cfg_done),
      .io_cfg   (io_cfg),
      .links    (link),
      .ext_out  (ext_out)
   );

endmodule

/* src/io_block.sv */
`timescale 1ns/100ps
`include "fabric_params.svh"

module io_block (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cfg_done,
   input  fabric_pkg::io_cfg_t  io_cfg,
   clb_link_if.drain            links [`FABRIC_NUM_CLB],
   output fabric_pkg::ext_out_t ext_out
);

   logic [`FABRIC_NUM_CLB-1:0] results;
   fabric_pkg::ext_out_t out_next;

   // flatten so the output muxes can index by select
   for (genvar i = 0; i < `FABRIC_NUM_CLB; i++) begin : g_gather
      assign results[i] = links[i].result;
   end

   always_comb begin
      fabric_pkg::out_sel_t sel;
      for (int o = 0; o < `FABRIC_NUM_OUT; o++) begin
         sel = io_cfg[o*`FABRIC_OSEL_W +: `FABRIC_OSEL_W];
         out_next[o] = results[sel];
      end
   end

   always_ff @(posedge clk) begin
      if (rst || !cfg_done) begin
         ext_out <= '0; // quiet until configured
      end else begin
         ext_out <= out_next;
      end
   end

endmodule

/* verification/fabric_checker.sv */
`timescale 1ns/100ps
`include "fabric_params.svh"

module fabric_checker (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cfg_valid,
   input  logic                 cfg_bit,
   input  fabric_pkg::track_t   ext_in,
   input  logic                 cfg_done,
   input  fabric_pkg::ext_out_t ext_out,
   output int                   check_count,
   output int                   error_count
);

   localparam int CFG_BITS = `FABRIC_CFG_BITS;
   localparam int ROUTE_W = `FABRIC_NUM_CLB * `FABRIC_CLBIN * `FABRIC_SEL_W;
   localparam int LUT_W = 1 << `FABRIC_CLBIN;
   localparam int CLB_CFG_W = LUT_W + 2;
   localparam int IO_BASE = ROUTE_W + `FABRIC_NUM_CLB * CLB_CFG_W;

   typedef logic [`FABRIC_NUM_CLB-1:0] clb_vec_t;

   fabric_pkg::cfg_frame_t m_frame;
   fabric_pkg::cfg_frame_t active;
   int m_count;
   logic m_done;
   clb_vec_t m_regs;
   clb_vec_t values;
   clb_vec_t results;
   fabric_pkg::ext_out_t m_out;
   logic armed = 1'b0;
   int checks = 0;
   int errors = 0;

   assign check_count = checks;
   assign error_count = errors;

   // value and visible result of every clb, carry enters clb 0 as zero
   function automatic void eval_column(
      input  fabric_pkg::cfg_frame_t frame,
      input  fabric_pkg::track_t     tracks,
      input  clb_vec_t               regs,
      output clb_vec_t               vals,
      output clb_vec_t               res
   );
      int base;
      logic carry;
      logic [1:0] total;
      fabric_pkg::clb_in_t ins;
      carry = 1'b0;
      for (int i = 0; i < `FABRIC_NUM_CLB; i++) begin
         base = ROUTE_W + i * CLB_CFG_W;
         for (int j = 0; j < `FABRIC_CLBIN; j++) begin
            ins[j] = tracks[frame[(i * `FABRIC_CLBIN + j) * `FABRIC_SEL_W +: `FABRIC_SEL_W]];
         end
         if (frame[base + LUT_W + 1]) begin
            total = {1'b0, ins[0]} + {1'b0, ins[1]} + {1'b0, carry};
            vals[i] = total[0];
            carry = total[1];
         end else begin
            vals[i] = frame[base + ins]; // truth table lookup
            carry = 1'b0;
         end
         res[i] = frame[base + LUT_W] ? regs[i] : vals[i];
      end
   endfunction

   function automatic fabric_pkg::ext_out_t select_outputs(
      input fabric_pkg::cfg_frame_t frame,
      input clb_vec_t               res
   );
      fabric_pkg::ext_out_t outs;
      for (int o = 0; o < `FABRIC_NUM_OUT; o++) begin
         outs[o] = res[frame[IO_BASE + o * `FABRIC_OSEL_W +: `FABRIC_OSEL_W]];
      end
      return outs;
   endfunction

   // model state advances on the same edge as the dut
   always @(posedge clk) begin
      if (rst) begin
         m_frame = '0;
         m_count = 0;
         m_done = 1'b0;
         m_regs = '0;
         m_out = '0;
         armed = 1'b1;
      end else begin
         active = m_done ? m_frame : '0; // frame only applies once complete
         eval_column(active, ext_in, m_regs, values, results);
         m_out = m_done ? select_outputs(active, results) : '0;
         m_regs = values;
         if (cfg_valid && !m_done) begin
            m_frame[m_count] = cfg_bit;
            m_count = m_count + 1;
            if (m_count == CFG_BITS) begin
               m_done = 1'b1;
            end
         end
      end
   end

   always @(negedge clk) begin
      if (armed) begin
         checks = checks + 1;
         if (cfg_done !== m_done) begin
            errors = errors + 1;
            $display("Fail cfg_done: got %h, expected %h at %0t", cfg_done, m_done, $time);
         end
         if (ext_out !== m_out) begin
            errors = errors + 1;
            $display("Fail ext_out: got %h, expected %h at %0t", ext_out, m_out, $time);
         end
      end
   end

endmodule

/* verification/tb_fpga_fabric.sv */
`timescale 1ns/100ps
`include "fabric_params.svh"

module tb_fpga_fabric;

   localparam int CLK_PERIOD = 4;
   localparam int RST_CYCLES = 5;
   localparam int CFG_BITS = `FABRIC_CFG_BITS;
   localparam int ROUTE_W = `FABRIC_NUM_CLB * `FABRIC_CLBIN * `FABRIC_SEL_W;
   localparam int LUT_W = 1 << `FABRIC_CLBIN;
   localparam int CLB_CFG_W = LUT_W + 2;
   localparam int IO_BASE = ROUTE_W + `FABRIC_NUM_CLB * CLB_CFG_W;
   localparam int IDLE_CYCLES = 20;
   localparam int PARTIAL_BITS = 50;
   localparam int TRAFFIC_CYCLES = 200;
   localparam int CARRY_CYCLES = 100;
   localparam int DONE_WAIT = 4;
   // a load can take twice its bit count with gaps
   localparam int TEST_CYCLES = 6 * (RST_CYCLES + 1) + 3 * IDLE_CYCLES + 2 * PARTIAL_BITS
      + 5 * (2 * CFG_BITS + DONE_WAIT) + 4 * TRAFFIC_CYCLES + CARRY_CYCLES;
   localparam int MARGIN_CYCLES = 100;

   logic clk;
   logic rst;
   logic cfg_valid;
   logic cfg_bit;
   fabric_pkg::track_t ext_in;
   logic cfg_done;
   fabric_pkg::ext_out_t ext_out;

   integer seed = 32'h5cebd659;
   int tb_errors = 0;
   int check_count;
   int checker_errors;
   fabric_pkg::cfg_frame_t frame;

   fpga_fabric fpga_fabric_inst (
      .clk       (clk),
      .rst       (rst),
      .cfg_valid (cfg_valid),
      .cfg_bit   (cfg_bit),
      .ext_in    (ext_in),
      .cfg_done  (cfg_done),
      .ext_out   (ext_out)
   );

   fabric_checker monitor_inst (
      .clk         (clk),
      .rst         (rst),
      .cfg_valid   (cfg_valid),
      .cfg_bit     (cfg_bit),
      .ext_in      (ext_in),
      .cfg_done    (cfg_done),
      .ext_out     (ext_out),
      .check_count (check_count),
      .error_count (checker_errors)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic drive(input logic valid, input logic bit_val);
      logic [31:0] rnd;
      @(posedge clk);
      #1;
      rnd = $random(seed);
      cfg_valid = valid;
      cfg_bit = bit_val;
      ext_in = rnd[`FABRIC_TRACKS-1:0];
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1;
      rst = 1'b1;
      cfg_valid = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
   endtask

   task automatic run_traffic(input int cycles, input logic allow_bits);
      logic [31:0] rnd;
      repeat (cycles) begin
         rnd = $random(seed);
         drive(allow_bits & rnd[0], rnd[1]); // stray bits after done
      end
   endtask

   task automatic load_frame(input fabric_pkg::cfg_frame_t f, input int nbits);
      logic [31:0] rnd;
      for (int k = 0; k < nbits; k++) begin
         rnd = $random(seed);
         if (rnd[1:0] == 2'b00) begin
            drive(1'b0, rnd[2]); // gap, bit must be ignored
         end
         drive(1'b1, f[k]);
      end
   endtask

   task automatic wait_for_done();
      int n;
      n = 0;
      while (!cfg_done && n < DONE_WAIT) begin
         drive(1'b0, 1'b0);
         n++;
      end
      if (!cfg_done) begin
         tb_errors++;
         $display("cfg_done did not rise after the full frame was sent at %0t", $time);
      end
   endtask

   task automatic make_random_frame(input logic reg_on, output fabric_pkg::cfg_frame_t f);
      int base;
      for (int w = 0; w < CFG_BITS / 32; w++) begin
         f[w*32 +: 32] = $random(seed);
      end
      for (int i = 0; i < `FABRIC_NUM_CLB; i++) begin
         base = ROUTE_W + i * CLB_CFG_W;
         f[base + LUT_W] = reg_on & f[base + LUT_W]; // about half registered
         f[base + LUT_W + 1] = 1'b0;
      end
   endtask

   // clb i adds track i and track i+4, output i shows clb i
   task automatic make_carry_frame(output fabric_pkg::cfg_frame_t f);
      int base;
      make_random_frame(1'b0, f);
      for (int i = 0; i < `FABRIC_NUM_CLB; i++) begin
         base = ROUTE_W + i * CLB_CFG_W;
         f[(i * `FABRIC_CLBIN) * `FABRIC_SEL_W +: `FABRIC_SEL_W] = i[`FABRIC_SEL_W-1:0];
         f[(i * `FABRIC_CLBIN + 1) * `FABRIC_SEL_W +: `FABRIC_SEL_W] =
            3'(i + `FABRIC_TRACKS / 2);
         f[base + LUT_W + 1] = 1'b1;
         f[IO_BASE + i * `FABRIC_OSEL_W +: `FABRIC_OSEL_W] = i[`FABRIC_OSEL_W-1:0];
      end
   endtask

   task automatic run_carry_sums(input int cycles);
      logic [3:0] expected;
      logic have_prev;
      have_prev = 1'b0;
      repeat (cycles) begin
         drive(1'b0, 1'b0);
         if (have_prev && ext_out !== expected) begin
            tb_errors++;
            $display("Fail ext_out: got %h, expected sum %h at %0t", ext_out, expected, $time);
         end
         expected = ext_in[3:0] + ext_in[7:4];
         have_prev = 1'b1;
      end
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      cfg_valid = 1'b0;
      cfg_bit = 1'b0;
      ext_in = '0;
      apply_reset();
      run_traffic(IDLE_CYCLES, 1'b0);
      make_random_frame(1'b0, frame);
      load_frame(frame, PARTIAL_BITS); // outputs must stay quiet
      run_traffic(IDLE_CYCLES, 1'b0);
      apply_reset();
      load_frame(frame, CFG_BITS);
      wait_for_done();
      run_traffic(TRAFFIC_CYCLES, 1'b1);
      apply_reset();
      make_random_frame(1'b1, frame);
      load_frame(frame, CFG_BITS);
      wait_for_done();
      run_traffic(TRAFFIC_CYCLES, 1'b1);
      apply_reset();
      make_carry_frame(frame);
      load_frame(frame, CFG_BITS);
      wait_for_done();
      run_carry_sums(CARRY_CYCLES);
      apply_reset();
      make_random_frame(1'b1, frame);
      load_frame(frame, CFG_BITS);
      wait_for_done();
      run_traffic(TRAFFIC_CYCLES / 2, 1'b1);
      apply_reset(); // mid run, then a fresh frame
      run_traffic(IDLE_CYCLES, 1'b0);
      make_random_frame(1'b0, frame);
      load_frame(frame, CFG_BITS);
      wait_for_done();
      run_traffic(TRAFFIC_CYCLES, 1'b1);
      @(posedge clk);
      #1;
      $display("checks %0d, checker errors %0d, testbench errors %0d",
               check_count, checker_errors, tb_errors);
      if (checker_errors == 0 && tb_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
      $display("timeout, the run did not finish within %0d cycles",
               TEST_CYCLES + MARGIN_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule
